/* design/rvga_pkg.sv */
`default_nettype none

package rvga_pkg;

  //////////////////////////////
  // geometry

  localparam int WORD_W      = 32;
  localparam int LINE_WORDS  = 8;
  localparam int LINE_W      = WORD_W * LINE_WORDS;
  localparam int CACHE_LINES = 8;
  localparam int MEM_LINES   = 64;   // 2 KB of backing store.
  localparam int MEM_LATENCY = 4;    // busy cycles before resp.

  localparam int BYTE_OFF_W = $clog2(WORD_W / 8);
  localparam int WORD_OFF_W = $clog2(LINE_WORDS);
  localparam int LINE_OFF_W = WORD_OFF_W + BYTE_OFF_W;
  localparam int INDEX_W    = $clog2(CACHE_LINES);
  localparam int TAG_W      = WORD_W - INDEX_W - LINE_OFF_W;
  localparam int MEM_IDX_W  = $clog2(MEM_LINES);
  localparam int MEM_LAT_W  = $clog2(MEM_LATENCY + 1);

  //////////////////////////////
  // fsm state codes

  localparam logic [1:0] MEM_IDLE    = 2'd0;
  localparam logic [1:0] MEM_BUSY    = 2'd1;
  localparam logic [1:0] MEM_RESPOND = 2'd2;

  localparam logic [1:0] CACHE_LOOKUP    = 2'd0;
  localparam logic [1:0] CACHE_WRITEBACK = 2'd1;
  localparam logic [1:0] CACHE_FILL      = 2'd2;
  localparam logic [1:0] CACHE_RESPOND   = 2'd3;

  typedef logic [WORD_W-1:0] rvga_word;
  typedef logic [LINE_W-1:0] rvga_cacheline;

  // same word, seen raw by the bus and split by the cache.
  typedef union packed {
    rvga_word raw;
    struct packed {
      logic [TAG_W-1:0]      tag;
      logic [INDEX_W-1:0]    index;
      logic [WORD_OFF_W-1:0] word_off;
      logic [BYTE_OFF_W-1:0] byte_off;
    } f;
  } rvga_addr_t;

endpackage

`default_nettype wire

/* design/rvga_membus_if.sv */
`default_nettype none

interface rvga_membus_if ();
  import rvga_pkg::*;

  logic          read_i;
  logic          write_i;
  rvga_word      addr_i;    // line aligned.
  rvga_cacheline wdata_i;
  rvga_cacheline rdata_o;
  logic          resp_o;    // one cycle pulse.

  modport master (
    output read_i, write_i, addr_i, wdata_i,
    input  rdata_o, resp_o
  );

  modport slave (
    input  read_i, write_i, addr_i, wdata_i,
    output rdata_o, resp_o
  );

endinterface

`default_nettype wire

/* design/line_mem.sv */
`default_nettype none

module line_mem (
  input  logic         clk,
  input  logic         rst_i,
  rvga_membus_if.slave bus
);
  import rvga_pkg::*;

  rvga_cacheline        mem_q [MEM_LINES];
  logic [1:0]           state_q;
  logic [MEM_LAT_W-1:0] lat_cnt_q;
  logic [MEM_IDX_W-1:0] line_idx;
  logic                 act;

  assign line_idx = bus.addr_i[LINE_OFF_W +: MEM_IDX_W];  // wraps at MEM_LINES.
  assign act = (state_q == MEM_BUSY) && (lat_cnt_q == MEM_LAT_W'(MEM_LATENCY - 1));
  assign bus.resp_o = (state_q == MEM_RESPOND);

  //////////////////////////////
  // identity fill

  // every word starts out holding its own byte address.
  initial begin
    for (int l = 0; l < MEM_LINES; l++) begin
      for (int w = 0; w < LINE_WORDS; w++) begin
        mem_q[l][w*WORD_W +: WORD_W] = rvga_word'((l * LINE_WORDS + w) * (WORD_W / 8));
      end
    end
  end

  //////////////////////////////
  // control

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q   <= MEM_IDLE;
      lat_cnt_q <= '0;
    end else begin
      case (state_q)
        MEM_IDLE: begin
          lat_cnt_q <= '0;
          if (bus.read_i || bus.write_i) begin
            state_q <= MEM_BUSY;
          end
        end
        MEM_BUSY: begin
          lat_cnt_q <= lat_cnt_q + 1'b1;
          if (act) begin
            state_q <= MEM_RESPOND;   // resp high next cycle.
          end
        end
        MEM_RESPOND: begin
          state_q <= MEM_IDLE;
        end
        default: begin
          state_q <= MEM_IDLE;
        end
      endcase
    end
  end

  //////////////////////////////
  // storage

  always_ff @(posedge clk) begin
    if (act) begin
      if (bus.write_i) begin
        mem_q[line_idx] <= bus.wdata_i;
      end else begin
        bus.rdata_o <= mem_q[line_idx];  // valid with resp.
      end
    end
  end

endmodule

`default_nettype wire

/* design/word_cache.sv */
`default_nettype none

module word_cache (
  input  logic                 clk,
  input  logic                 rst_i,
  input  logic                 read_i,
  input  logic                 write_i,
  input  rvga_pkg::rvga_word   addr_i,
  input  rvga_pkg::rvga_word   wdata_i,
  output rvga_pkg::rvga_word   rdata_o,
  output logic                 resp_o,
  rvga_membus_if.master        mem
);
  import rvga_pkg::*;

  rvga_cacheline          data_q [CACHE_LINES];
  logic [TAG_W-1:0]       tag_q  [CACHE_LINES];
  logic [CACHE_LINES-1:0] valid_q;
  logic [CACHE_LINES-1:0] dirty_q;
  logic [1:0]             state_q;
  logic                   mem_read_q;
  logic                   mem_write_q;
  rvga_word               rdata_q;

  rvga_addr_t             req;
  logic [INDEX_W-1:0]     idx;
  logic                   req_valid;
  logic                   hit;
  logic                   lookup_hit;
  logic                   fill_done;
  rvga_cacheline          cur_line;
  rvga_word               victim_addr;
  rvga_word               fill_addr;

  //////////////////////////////
  // decode

  assign req.raw     = addr_i;
  assign idx         = req.f.index;
  assign req_valid   = read_i || write_i;
  assign cur_line    = data_q[idx];
  assign hit         = valid_q[idx] && (tag_q[idx] == req.f.tag);
  assign lookup_hit  = (state_q == CACHE_LOOKUP) && req_valid && hit;
  assign fill_done   = (state_q == CACHE_FILL) && mem.resp_o;
  assign victim_addr = {tag_q[idx], idx, LINE_OFF_W'(0)};
  assign fill_addr   = {req.f.tag, idx, LINE_OFF_W'(0)};

  assign mem.read_i  = mem_read_q;
  assign mem.write_i = mem_write_q;
  assign mem.addr_i  = (state_q == CACHE_WRITEBACK) ? victim_addr : fill_addr;
  assign mem.wdata_i = cur_line;     // victim line during write-back.

  assign rdata_o = rdata_q;
  assign resp_o  = (state_q == CACHE_RESPOND);

  //////////////////////////////
  // control

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q     <= CACHE_LOOKUP;
      mem_read_q  <= 1'b0;
      mem_write_q <= 1'b0;
      valid_q     <= '0;
      dirty_q     <= '0;
    end else begin
      case (state_q)
        CACHE_LOOKUP: begin
          if (req_valid) begin
            if (hit) begin
              state_q <= CACHE_RESPOND;
              if (write_i) begin
                dirty_q[idx] <= 1'b1;
              end
            end else if (valid_q[idx] && dirty_q[idx]) begin
              state_q     <= CACHE_WRITEBACK;
              mem_write_q <= 1'b1;
            end else begin
              state_q <= CACHE_FILL;
            end
          end
        end
        CACHE_WRITEBACK: begin
          if (mem.resp_o) begin
            mem_write_q <= 1'b0;
            state_q     <= CACHE_FILL;   // bus idles one cycle first.
          end
        end
        CACHE_FILL: begin
          if (mem.resp_o) begin
            mem_read_q   <= 1'b0;
            valid_q[idx] <= 1'b1;
            dirty_q[idx] <= 1'b0;
            state_q      <= CACHE_LOOKUP; // retry as a hit.
          end else begin
            mem_read_q <= 1'b1;
          end
        end
        CACHE_RESPOND: begin
          state_q <= CACHE_LOOKUP;
        end
        default: begin
          state_q <= CACHE_LOOKUP;
        end
      endcase
    end
  end

  //////////////////////////////
  // data and tags

  always_ff @(posedge clk) begin
    if (lookup_hit) begin
      if (write_i) begin
        data_q[idx][req.f.word_off*WORD_W +: WORD_W] <= wdata_i;
      end else begin
        rdata_q <= cur_line[req.f.word_off*WORD_W +: WORD_W];
      end
    end
    if (fill_done) begin
      data_q[idx] <= mem.rdata_o;
      tag_q[idx]  <= req.f.tag;
    end
  end

endmodule

`default_nettype wire

/* design/rvga_mem_top.sv */
`default_nettype none

module rvga_mem_top (
  input  logic               clk,
  input  logic               rst_i,
  input  logic               read_i,
  input  logic               write_i,
  input  rvga_pkg::rvga_word addr_i,   // word aligned.
  input  rvga_pkg::rvga_word wdata_i,
  output rvga_pkg::rvga_word rdata_o,
  output logic               resp_o
);

  //////////////////////////////
  // cache to memory bus

  rvga_membus_if membus ();

  word_cache i_word_cache (
    .clk     (clk),
    .rst_i   (rst_i),
    .read_i  (read_i),
    .write_i (write_i),
    .addr_i  (addr_i),
    .wdata_i (wdata_i),
    .rdata_o (rdata_o),
    .resp_o  (resp_o),
    .mem     (membus.master)
  );

  line_mem i_line_mem (
    .clk   (clk),
    .rst_i (rst_i),
    .bus   (membus.slave)
  );

endmodule

`default_nettype wire

/* dv/rvga_mem_tb.sv */
`default_nettype none

module rvga_mem_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import rvga_pkg::*;

  localparam int MEM_WORDS  = MEM_LINES * LINE_WORDS;
  localparam int REQ_CYCLES = 2 * (MEM_LATENCY + 2) + 4;   // worst case, dirty miss.
  localparam int NUM_RAND   = 300;
  localparam int NUM_DIR    = 23;   // directed plus read-back.
  localparam int LIMIT      = (NUM_RAND + NUM_DIR) * REQ_CYCLES + 50;

  logic     clk;
  logic     rst_i;
  logic     read_i;
  logic     write_i;
  rvga_word addr_i;
  rvga_word wdata_i;
  rvga_word rdata_o;
  logic     resp_o;

  rvga_word ref_mem [MEM_WORDS];
  logic [31:0] seed;
  int       mismatches;
  int       protocol_errs;
  int       cycle_cnt;

  rvga_mem_top i_rvga_mem_top (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////
  // protocol checks

  a_resp_has_req: assert property (@(posedge clk) disable iff (rst_i)
      $rose(resp_o) |-> $past(read_i || write_i))
    else begin
      $display("resp_o rose at %0t with no request pending", $time);
      protocol_errs++;
    end

  a_resp_pulse: assert property (@(posedge clk) disable iff (rst_i) resp_o |=> !resp_o)
    else begin
      $display("resp_o stayed high for more than one cycle at %0t", $time);
      protocol_errs++;
    end

  //////////////////////////////
  // helpers

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int word_of(input rvga_word addr);
    return int'(addr >> 2) % MEM_WORDS;
  endfunction

  // called on a falling edge, returns on a falling edge.
  task automatic do_request(input logic is_write, input rvga_word addr, input rvga_word data,
                            output rvga_word rdata, output int cycles);
    read_i  = !is_write;
    write_i = is_write;
    addr_i  = addr;
    wdata_i = data;
    cycles  = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!resp_o && cycles < REQ_CYCLES);
    assert (resp_o) else begin
      $display("request to 0x%08h got no response within %0d cycles", addr, REQ_CYCLES);
      protocol_errs++;
    end
    rdata   = rdata_o;
    read_i  = 1'b0;
    write_i = 1'b0;
    @(negedge clk);   // idle gap.
  endtask

  task automatic write_word(input rvga_word addr, input rvga_word data);
    rvga_word got;
    int       cycles;
    do_request(1'b1, addr, data, got, cycles);
    ref_mem[word_of(addr)] = data;
  endtask

  task automatic read_check(input rvga_word addr, output int cycles);
    rvga_word got;
    rvga_word exp;
    exp = ref_mem[word_of(addr)];
    do_request(1'b0, addr, '0, got, cycles);
    assert (got === exp) else begin
      $display("Mismatch at %0t: read 0x%08h gave 0x%08h, expected 0x%08h",
               $time, addr, got, exp);
      mismatches++;
    end
  endtask

  //////////////////////////////
  // stimulus

  initial begin : main
    rvga_word addr;
    int       cycles;
    rst_i         = 1'b1;
    read_i        = 1'b0;
    write_i       = 1'b0;
    addr_i        = '0;
    wdata_i       = '0;
    seed          = 32'he447b41a;
    mismatches    = 0;
    protocol_errs = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      ref_mem[i] = rvga_word'(i * 4);   // identity contents.
    end
    repeat (3) @(negedge clk);
    rst_i = 1'b0;

    repeat (5) begin
      @(negedge clk);
      assert (!resp_o) else begin
        $display("resp_o went high after reset before any request");
        protocol_errs++;
      end
    end

    // untouched word, then write, hit, dirty eviction and refill.
    read_check(32'h0000_03f8, cycles);
    write_word(32'h0000_0124, 32'hcafe_0001);
    read_check(32'h0000_0124, cycles);
    write_word(32'h0000_0128, 32'hcafe_0002);
    read_check(32'h0000_0224, cycles);   // same index, evicts dirty line.
    read_check(32'h0000_0124, cycles);
    read_check(32'h0000_0128, cycles);

    read_check(32'h0000_05e0, cycles);
    read_check(32'h0000_05e0, cycles);
    assert (cycles <= 2) else begin
      $display("repeated read took %0d cycles where a hit allows 2", cycles);
      protocol_errs++;
    end

    addr = '0;
    for (int n = 0; n < NUM_RAND; n++) begin
      seed = lcg_next(seed);
      if (seed[29:28] != 2'b00) begin
        addr = rvga_word'((seed[27:8] % MEM_WORDS) * 4);   // else reuse last word.
      end
      if (seed[31]) begin
        write_word(addr, lcg_next(seed));
      end else begin
        read_check(addr, cycles);
      end
    end

    // sparse read-back across the whole memory.
    for (int i = 0; i < MEM_WORDS; i += 37) begin
      read_check(rvga_word'(i * 4), cycles);
    end

    $display("errors: %0d mismatches, %0d protocol", mismatches, protocol_errs);
    if (mismatches == 0 && protocol_errs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d cycles", cycle_cnt);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
design/rvga_pkg.sv
design/rvga_membus_if.sv
design/line_mem.sv
design/word_cache.sv
design/rvga_mem_top.sv
dv/rvga_mem_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it, and checks for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module rvga_mem_tb -f compile.f -o rvga_mem_sim \
  && out="$(./obj_dir/rvga_mem_sim)" \
  && echo "$out" \
  && echo "$out" | grep -q "Result: PASSED" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
